// File: sim.f
+incdir+source
source/stm_pkg.sv
source/stm_trace_sampler.sv
source/stm_event_fifo.sv
source/stm_packetizer.sv
source/stm_regaccess.sv
source/stm_top.sv
tb/stm_clock_gen.sv
tb/stm_assertions.sv
tb/stm_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then look for the pass message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sim.f --top-module stm_tb -o stm_sim \
   && ./obj_dir/stm_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Verification passed" sim.log 2>/dev/null \
   && echo "run.sh: simulation passed" \
   || { echo "run.sh: simulation failed"; exit 1; }

// File: tb/stm_tb.sv
`timescale 1ns/1ns
`include "stm_defs.svh"

module stm_tb import stm_pkg::*; ();

   localparam node_id_t TB_ID   = 10'h005;
   localparam int       TIMEOUT = 2000;

   typedef struct packed {
      logic [3:0]       len;
      flit_data_t [9:0] f;
   } packet_t;

   logic         clk;
   logic         rst_n;
   dii_flit_t    debug_in;
   logic         debug_in_ready;
   dii_flit_t    debug_out;
   logic         debug_out_ready;
   logic         trace_valid;
   trace_id_t    trace_id;
   trace_value_t trace_value;

   timestamp_t   cycle;
   logic [31:0]  lcg_state;
   trace_id_t    next_id;
   logic         ctrl_model; // expected control bit 0
   packet_t      rx_q[$];
   packet_t      exp_reg_q[$];
   packet_t      exp_ev_q[$];
   int           ovf_credit; // overflow counts not yet matched to a gap
   int           ovf_total;
   int           trace_pkts;

   stm_clock_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

   stm_top dut_i (
      .clk             (clk),
      .rst_n           (rst_n),
      .id              (TB_ID),
      .debug_in        (debug_in),
      .debug_in_ready  (debug_in_ready),
      .debug_out       (debug_out),
      .debug_out_ready (debug_out_ready),
      .trace_valid     (trace_valid),
      .trace_id        (trace_id),
      .trace_value     (trace_value)
   );

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) cycle <= '0;
      else cycle <= cycle + 1'b1; // mirrors the stamp counter
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   task automatic report_error(string line);
      $display("%s", line);
      $display("Verification failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_flit(flit_data_t got, flit_data_t want, string what);
      if (got !== want)
         report_error($sformatf("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, want));
   endtask

   task automatic check_timestamp(timestamp_t got, timestamp_t want, string what);
      if (got !== want)
         report_error($sformatf("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, want));
   endtask

   task automatic check_count(drop_count_t got, drop_count_t want, string what);
      if (got !== want)
         report_error($sformatf("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, want));
   endtask

   function automatic packet_t expected_event(trace_id_t ev_id, trace_value_t value,
                                              timestamp_t ts);
      packet_t p;
      p = '0;
      p.len  = 4'd10;
      p.f[0] = '0; // trace sink
      p.f[1] = flit_data_t'(TB_ID);
      p.f[2] = `STM_TYPE_EVENT;
      p.f[3] = ts[15:0];
      p.f[4] = ts[31:16];
      p.f[5] = ev_id;
      p.f[6] = value[15:0];
      p.f[7] = value[31:16];
      p.f[8] = value[47:32];
      p.f[9] = value[63:48];
      return p;
   endfunction

   function automatic packet_t expected_response(flit_data_t rtype, flit_data_t addr,
                                                 flit_data_t src, logic ctrl);
      packet_t    p;
      logic       readable;
      flit_data_t rdata;
      p        = '0;
      readable = 1'b1;
      rdata    = '0;
      if (addr == `STM_REG_ID) rdata = `STM_MOD_ID;
      else if (addr == `STM_REG_VERSION) rdata = `STM_MOD_VERSION;
      else if (addr == `STM_REG_CONTROL) rdata = {15'b0, ctrl};
      else readable = 1'b0;
      p.f[0] = src; // back to requester
      p.f[1] = flit_data_t'(TB_ID);
      p.len  = 4'd3;
      if (rtype == `STM_TYPE_REG_READ && readable) begin
         p.f[2] = `STM_TYPE_RESP_OK;
         p.f[3] = rdata;
         p.len  = 4'd4;
      end else if (rtype == `STM_TYPE_REG_WRITE && addr == `STM_REG_CONTROL) begin
         p.f[2] = `STM_TYPE_RESP_OK;
      end else begin
         p.f[2] = `STM_TYPE_RESP_ERR;
      end
      return p;
   endfunction

   task automatic compare_packet(packet_t p);
      packet_t    ref_pkt;
      flit_data_t ptype;
      logic [3:0] k;
      int         gap;
      ptype = p.f[2];
      if (ptype == `STM_TYPE_RESP_OK || ptype == `STM_TYPE_RESP_ERR) begin
         if (exp_reg_q.size() == 0) begin
            report_error("a response packet arrived with no request outstanding");
         end else begin
            ref_pkt = exp_reg_q.pop_front();
            check_flit(flit_data_t'(p.len), flit_data_t'(ref_pkt.len), "response length");
            for (k = 4'd0; k < ref_pkt.len; k++)
               check_flit(p.f[k], ref_pkt.f[k], "response flit");
         end
      end else if (ptype == `STM_TYPE_OVERFLOW) begin
         check_flit(flit_data_t'(p.len), 16'd4, "overflow length");
         check_flit(p.f[0], '0, "overflow destination");
         check_flit(p.f[1], flit_data_t'(TB_ID), "overflow source");
         ovf_credit += int'(p.f[3]);
         ovf_total  += int'(p.f[3]);
         trace_pkts++;
      end else if (ptype == `STM_TYPE_EVENT) begin
         check_flit(flit_data_t'(p.len), 16'd10, "event length");
         gap = 0;
         while (exp_ev_q.size() > 0 && exp_ev_q[0].f[5] != p.f[5]) begin
            void'(exp_ev_q.pop_front()); // dropped on the way
            gap++;
         end
         if (exp_ev_q.size() == 0) begin
            report_error("an event packet carries an id that was not sent or is out of order");
         end else if (gap > ovf_credit) begin
            report_error("events went missing without an overflow packet before them");
         end else begin
            ovf_credit -= gap;
            ref_pkt = exp_ev_q.pop_front();
            check_flit(p.f[0], ref_pkt.f[0], "event destination");
            check_flit(p.f[1], ref_pkt.f[1], "event source");
            check_timestamp({p.f[4], p.f[3]}, {ref_pkt.f[4], ref_pkt.f[3]}, "event timestamp");
            for (k = 4'd6; k < 4'd10; k++)
               check_flit(p.f[k], ref_pkt.f[k], "event value");
            trace_pkts++;
         end
      end else begin
         report_error($sformatf("a packet arrived with unknown type %h", ptype));
      end
   endtask

   // collects packets mid low phase where debug_out is settled
   initial begin
      packet_t    cur;
      logic [3:0] cur_len;
      cur     = '0;
      cur_len = '0;
      forever begin
         @(negedge clk);
         #10;
         if (rst_n && debug_out.valid && debug_out_ready) begin
            if (cur_len == 4'd10) report_error("an output packet ran past ten flits");
            cur.f[cur_len] = debug_out.data;
            cur_len++;
            if (debug_out.last) begin
               cur.len = cur_len;
               rx_q.push_back(cur);
               cur     = '0;
               cur_len = '0;
            end
         end
      end
   end

   initial begin
      forever begin
         @(posedge clk);
         while (rx_q.size() > 0) compare_packet(rx_q.pop_front());
      end
   end

   always @(negedge clk) begin
      if (dut_i.asrt_i.fail_count != 0) report_error("an assertion on the debug ports failed");
   end

   task automatic send_flit(flit_data_t data, logic last);
      int t;
      @(negedge clk);
      debug_in = '{valid: 1'b1, last: last, data: data};
      t = 0;
      #10;
      while (!debug_in_ready) begin
         if (t == TIMEOUT) report_error("timeout: debug_in_ready stayed low");
         t++;
         @(negedge clk);
         #10;
      end
   endtask

   task automatic wait_responses();
      int t;
      t = 0;
      while (exp_reg_q.size() != 0) begin
         if (t == TIMEOUT) report_error("timeout: a register response did not arrive");
         t++;
         @(negedge clk);
      end
   endtask

   task automatic do_request(flit_data_t rtype, flit_data_t addr, flit_data_t wdata,
                             flit_data_t src);
      logic is_write;
      is_write = (rtype == `STM_TYPE_REG_WRITE);
      exp_reg_q.push_back(expected_response(rtype, addr, src, ctrl_model));
      if (is_write && addr == `STM_REG_CONTROL) ctrl_model = wdata[0];
      send_flit(flit_data_t'(TB_ID), 1'b0);
      send_flit(src, 1'b0);
      send_flit(rtype, 1'b0);
      send_flit(addr, !is_write);
      if (is_write) send_flit(wdata, 1'b1);
      @(negedge clk);
      debug_in = '0;
      wait_responses();
   endtask

   task automatic send_events(int count, int gap);
      trace_value_t v;
      repeat (count) begin
         @(negedge clk);
         v           = {lcg_next(), lcg_next()};
         trace_valid = 1'b1;
         trace_id    = next_id;
         trace_value = v;
         if (!ctrl_model) exp_ev_q.push_back(expected_event(next_id, v, cycle)); // stalled events vanish
         next_id++;
         repeat (gap) begin
            @(negedge clk);
            trace_valid = 1'b0;
         end
      end
      @(negedge clk);
      trace_valid = 1'b0;
   endtask

   task automatic drive_random_ready(int count);
      logic [31:0] r;
      repeat (count) begin
         @(negedge clk);
         r               = lcg_next();
         debug_out_ready = r[16];
      end
      @(negedge clk);
      debug_out_ready = 1'b1;
   endtask

   task automatic wait_quiet();
      int idle;
      int t;
      idle = 0;
      t    = 0;
      while (idle < 40) begin
         @(negedge clk);
         #10;
         if (debug_out.valid) idle = 0;
         else idle++;
         if (t == TIMEOUT) report_error("timeout: debug_out never went idle");
         t++;
      end
   endtask

   initial begin
      int t;
      int trace_before;
      lcg_state       = 32'd32589;
      next_id         = 16'h0001;
      ctrl_model      = 1'b0;
      ovf_credit      = 0;
      ovf_total       = 0;
      trace_pkts      = 0;
      debug_in        = '0;
      debug_out_ready = 1'b1;
      trace_valid     = 1'b0;
      trace_id        = '0;
      trace_value     = '0;

      t = 0;
      while (!rst_n) begin
         if (t == TIMEOUT) report_error("timeout: reset was never released");
         t++;
         @(negedge clk);
      end
      repeat (2) @(negedge clk);

      // identity, version and unmapped addresses
      do_request(`STM_TYPE_REG_READ, `STM_REG_ID, '0, 16'h0011);
      do_request(`STM_TYPE_REG_READ, `STM_REG_VERSION, '0, 16'h0012);
      do_request(`STM_TYPE_REG_READ, 16'h0300, '0, 16'h0013);
      do_request(`STM_TYPE_REG_WRITE, 16'h0100, 16'h0001, 16'h0014);
      do_request(`STM_TYPE_REG_WRITE, `STM_REG_ID, 16'h0001, 16'h0015); // read only

      // widely spaced events without back-pressure
      send_events(10, 20);
      wait_quiet();
      check_count(drop_count_t'(exp_ev_q.size()), '0, "events still missing");
      check_count(drop_count_t'(ovf_total), '0, "dropped events");

      // events ignored while stalled
      do_request(`STM_TYPE_REG_WRITE, `STM_REG_CONTROL, 16'h0001, 16'h0021);
      do_request(`STM_TYPE_REG_READ, `STM_REG_CONTROL, '0, 16'h0022);
      trace_before = trace_pkts;
      send_events(10, 2);
      wait_quiet();
      check_count(drop_count_t'(trace_pkts - trace_before), '0, "trace packets while stalled");
      do_request(`STM_TYPE_REG_WRITE, `STM_REG_CONTROL, 16'h0000, 16'h0023);
      do_request(`STM_TYPE_REG_READ, `STM_REG_CONTROL, '0, 16'h0024);
      send_events(5, 20);
      wait_quiet();
      check_count(drop_count_t'(exp_ev_q.size()), '0, "events missing after stall");
      check_count(drop_count_t'(ovf_total), '0, "drops counted during stall");

      // blocked output during a burst, then release
      @(negedge clk);
      debug_out_ready = 1'b0;
      send_events(30, 0);
      @(negedge clk);
      debug_out_ready = 1'b1;
      send_events(30, 0);
      wait_quiet();
      check_count(drop_count_t'(exp_ev_q.size()), drop_count_t'(ovf_credit),
                  "undelivered events against overflow counts");
      if (ovf_total == 0) report_error("no events were dropped while debug_out was blocked");
      exp_ev_q.delete();
      ovf_credit = 0;

      // register traffic mixed into heavy trace traffic
      fork
         drive_random_ready(150);
         send_events(80, 0);
         begin
            repeat (20) @(negedge clk);
            do_request(`STM_TYPE_REG_READ, `STM_REG_VERSION, '0, 16'h0031);
            do_request(`STM_TYPE_REG_READ, `STM_REG_CONTROL, '0, 16'h0032);
         end
      join
      wait_quiet();
      check_count(drop_count_t'(exp_ev_q.size()), drop_count_t'(ovf_credit),
                  "undelivered events against overflow counts");

      if (dut_i.asrt_i.fail_count == 0) begin
         $display("Verification passed");
         $finish;
      end else begin
         report_error("an assertion on the debug ports failed");
      end
   end

endmodule

// File: tb/stm_assertions.sv
`timescale 1ns/1ns

module stm_assertions import stm_pkg::*; (
   input logic      clk,
   input logic      rst_n,
   input dii_flit_t debug_in,
   input logic      debug_in_ready,
   input dii_flit_t debug_out,
   input logic      debug_out_ready,
   input logic      stall
);

   int fail_count = 0;

   out_hold: assert property (@(posedge clk) disable iff (!rst_n)
      debug_out.valid && !debug_out_ready |=>
         debug_out.valid && $stable(debug_out.data) && $stable(debug_out.last))
      else begin
         fail_count++;
         $error("debug_out flit changed before it was accepted");
      end

   in_hold: assert property (@(posedge clk) disable iff (!rst_n)
      debug_in.valid && !debug_in_ready |=>
         debug_in.valid && $stable(debug_in.data) && $stable(debug_in.last))
      else begin
         fail_count++;
         $error("debug_in flit changed before it was accepted");
      end

   last_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
      !(debug_out.last && !debug_out.valid) && !(debug_in.last && !debug_in.valid))
      else begin
         fail_count++;
         $error("last flag seen without valid");
      end

   reset_state: assert property (@(posedge clk)
      !rst_n |-> !debug_out.valid && !stall && debug_in_ready)
      else begin
         fail_count++;
         $error("outputs not idle during reset");
      end

endmodule

bind stm_top stm_assertions asrt_i (
   .clk             (clk),
   .rst_n           (rst_n),
   .debug_in        (debug_in),
   .debug_in_ready  (debug_in_ready),
   .debug_out       (debug_out),
   .debug_out_ready (debug_out_ready),
   .stall           (stall)
);

// File: tb/stm_clock_gen.sv
`timescale 1ns/1ns

module stm_clock_gen (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk; // 40 ns period
   end

   initial begin
      rst_n = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

// File: source/stm_top.sv
`timescale 1ns/1ns

module stm_top import stm_pkg::*; (
   input  logic         clk,
   input  logic         rst_n,
   input  node_id_t     id,
   input  dii_flit_t    debug_in,
   output logic         debug_in_ready,
   output dii_flit_t    debug_out,
   input  logic         debug_out_ready,
   input  logic         trace_valid,
   input  trace_id_t    trace_id,
   input  trace_value_t trace_value
);

   logic         stall;
   trace_entry_t smp_entry;
   logic         smp_valid;
   logic         smp_ready;
   trace_entry_t buf_entry;
   logic         buf_valid;
   logic         buf_ready;
   dii_flit_t    trace_flit;
   logic         trace_flit_ready;

   stm_regaccess u_regaccess (
      .clk              (clk),
      .rst_n            (rst_n),
      .id               (id),
      .debug_in         (debug_in),
      .debug_in_ready   (debug_in_ready),
      .debug_out        (debug_out),
      .debug_out_ready  (debug_out_ready),
      .trace_flit       (trace_flit),
      .trace_flit_ready (trace_flit_ready),
      .stall            (stall)
   );

   stm_trace_sampler u_sampler (
      .clk         (clk),
      .rst_n       (rst_n),
      .stall       (stall),
      .trace_valid (trace_valid),
      .trace_id    (trace_id),
      .trace_value (trace_value),
      .entry_ready (smp_ready),
      .entry       (smp_entry),
      .entry_valid (smp_valid)
   );

   stm_event_fifo u_buffer (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_entry  (smp_entry),
      .in_valid  (smp_valid),
      .in_ready  (smp_ready),
      .out_entry (buf_entry),
      .out_valid (buf_valid),
      .out_ready (buf_ready)
   );

   stm_packetizer u_packetizer (
      .clk         (clk),
      .rst_n       (rst_n),
      .id          (id),
      .entry       (buf_entry),
      .entry_valid (buf_valid),
      .entry_ready (buf_ready),
      .flit        (trace_flit),
      .flit_ready  (trace_flit_ready)
   );

endmodule

// File: source/stm_regaccess.sv
`timescale 1ns/1ns
`include "stm_defs.svh"

module stm_regaccess import stm_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  node_id_t  id,
   input  dii_flit_t debug_in,
   output logic      debug_in_ready,
   output dii_flit_t debug_out,
   input  logic      debug_out_ready,
   input  dii_flit_t trace_flit,
   output logic      trace_flit_ready,
   output logic      stall
);

   reg_state_e state;
   logic [2:0] in_idx;
   logic       in_xfer;
   flit_data_t req_src;
   flit_data_t req_type;
   flit_data_t req_addr;
   logic       req_wbit;
   logic [2:0] req_len;
   logic       is_read;
   logic       is_write;

   logic       dec_ok;
   logic       dec_data;
   logic       dec_wr_ctrl;
   flit_data_t dec_rdata;

   logic       resp_ok;
   logic       resp_has_data;
   flit_data_t resp_rdata;
   logic [1:0] resp_idx;
   flit_data_t resp_data;
   logic       resp_last;
   dii_flit_t  resp_flit;
   logic       resp_xfer;

   logic       arb_busy;
   logic       arb_resp_q;
   logic       sel_resp;

   assign debug_in_ready = (state == REG_RECV);
   assign in_xfer        = debug_in.valid & debug_in_ready;

   assign is_read  = (req_type == `STM_TYPE_REG_READ) && (req_len == 3'd3);
   assign is_write = (req_type == `STM_TYPE_REG_WRITE) && (req_len == 3'd4);

   always_comb begin
      dec_ok      = 1'b0;
      dec_data    = 1'b0;
      dec_wr_ctrl = 1'b0;
      dec_rdata   = '0;
      case (req_addr)
         `STM_REG_ID: begin
            dec_ok    = is_read;
            dec_data  = is_read;
            dec_rdata = `STM_MOD_ID;
         end
         `STM_REG_VERSION: begin
            dec_ok    = is_read;
            dec_data  = is_read;
            dec_rdata = `STM_MOD_VERSION;
         end
         `STM_REG_CONTROL: begin
            dec_ok      = is_read | is_write;
            dec_data    = is_read;
            dec_wr_ctrl = is_write;
            dec_rdata   = flit_data_t'(stall);
         end
         default: ; // unmapped, error response
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= REG_RECV;
         in_idx   <= '0;
         resp_idx <= '0;
         stall    <= 1'b0;
      end else begin
         case (state)
            REG_RECV: if (in_xfer) begin
               if (debug_in.last) begin
                  state  <= REG_DECODE;
                  in_idx <= '0;
               end else if (in_idx != '1) begin
                  in_idx <= in_idx + 1'b1; // extra flits are dropped
               end
            end
            REG_DECODE: begin
               if (dec_wr_ctrl) stall <= req_wbit;
               resp_idx <= '0;
               state    <= REG_RESP;
            end
            REG_RESP: if (resp_xfer) begin
               if (resp_last) state <= REG_RECV;
               resp_idx <= resp_idx + 1'b1;
            end
            default: state <= REG_RECV;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (in_xfer) begin
         case (in_idx)
            3'd1: req_src  <= debug_in.data;
            3'd2: req_type <= debug_in.data;
            3'd3: req_addr <= debug_in.data;
            3'd4: req_wbit <= debug_in.data[0];
            default: ; // flit 0 is our own address
         endcase
         if (debug_in.last) req_len <= in_idx;
      end
      if (state == REG_DECODE) begin
         resp_ok       <= dec_ok;
         resp_has_data <= dec_ok & dec_data;
         resp_rdata    <= dec_rdata;
      end
   end

   always_comb begin
      case (resp_idx)
         2'd0:    resp_data = req_src; // reply to requester
         2'd1:    resp_data = flit_data_t'(id);
         2'd2:    resp_data = resp_ok ? `STM_TYPE_RESP_OK : `STM_TYPE_RESP_ERR;
         default: resp_data = resp_rdata;
      endcase
   end

   assign resp_last = resp_has_data ? (resp_idx == 2'd3) : (resp_idx == 2'd2);
   assign resp_flit = '{valid: (state == REG_RESP), last: resp_last, data: resp_data};

   // selection locks once a flit is offered, until the last one transfers
   assign sel_resp         = arb_busy ? arb_resp_q : resp_flit.valid;
   assign debug_out        = sel_resp ? resp_flit : trace_flit;
   assign trace_flit_ready = ~sel_resp & debug_out_ready;
   assign resp_xfer        = sel_resp & resp_flit.valid & debug_out_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         arb_busy   <= 1'b0;
         arb_resp_q <= 1'b0;
      end else if (debug_out.valid) begin
         arb_busy   <= ~(debug_out_ready & debug_out.last);
         arb_resp_q <= sel_resp;
      end
   end

endmodule

// File: source/stm_packetizer.sv
`timescale 1ns/1ns
`include "stm_defs.svh"

module stm_packetizer import stm_pkg::*; (
   input  logic         clk,
   input  logic         rst_n,
   input  node_id_t     id,
   input  trace_entry_t entry,
   input  logic         entry_valid,
   output logic         entry_ready,
   output dii_flit_t    flit,
   input  logic         flit_ready
);

   pkt_state_e state;
   logic [3:0] idx;
   flit_data_t data;
   logic       last;
   logic       xfer;

   always_comb begin
      case (idx)
         4'd0: data = '0; // trace sink at node 0
         4'd1: data = flit_data_t'(id);
         4'd2: data = entry.is_overflow ? `STM_TYPE_OVERFLOW : `STM_TYPE_EVENT;
         4'd3: data = entry.is_overflow ? entry.value[15:0] : entry.timestamp[15:0];
         4'd4: data = entry.timestamp[31:16];
         4'd5: data = entry.id;
         4'd6: data = entry.value[15:0];
         4'd7: data = entry.value[31:16];
         4'd8: data = entry.value[47:32];
         4'd9: data = entry.value[63:48];
         default: data = '0;
      endcase
   end

   assign last = (state == PKT_PAYLOAD) &&
                 ((idx == 4'd9) || (entry.is_overflow && idx == 4'd3));

   assign flit        = '{valid: (state != PKT_IDLE), last: last, data: data};
   assign xfer        = flit.valid & flit_ready;
   assign entry_ready = xfer & last; // pop on last flit

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= PKT_IDLE;
         idx   <= '0;
      end else begin
         case (state)
            PKT_IDLE: if (entry_valid) begin
               state <= PKT_HEADER;
               idx   <= '0;
            end
            PKT_HEADER: if (xfer) begin
               idx <= idx + 1'b1;
               if (idx == 4'd2) state <= PKT_PAYLOAD;
            end
            PKT_PAYLOAD: if (xfer) begin
               if (last) begin
                  state <= PKT_IDLE;
               end else begin
                  idx <= idx + 1'b1;
               end
            end
            default: state <= PKT_IDLE;
         endcase
      end
   end

endmodule

// File: source/stm_event_fifo.sv
`timescale 1ns/1ns
`include "stm_defs.svh"

module stm_event_fifo import stm_pkg::*; (
   input  logic         clk,
   input  logic         rst_n,
   input  trace_entry_t in_entry,
   input  logic         in_valid,
   output logic         in_ready,
   output trace_entry_t out_entry,
   output logic         out_valid,
   input  logic         out_ready
);

   localparam int DEPTH = `STM_FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   trace_entry_t     mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign in_ready  = (count != CNT_W'(DEPTH));
   assign out_valid = (count != '0);
   assign push      = in_valid & in_ready;
   assign pop       = out_valid & out_ready;
   assign out_entry = mem[rd_ptr];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= next_ptr(wr_ptr);
         if (pop) rd_ptr <= next_ptr(rd_ptr);
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ; // both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr] <= in_entry;
   end

endmodule

// File: source/stm_trace_sampler.sv
`timescale 1ns/1ns

module stm_trace_sampler import stm_pkg::*; (
   input  logic         clk,
   input  logic         rst_n,
   input  logic         stall,
   input  logic         trace_valid,
   input  trace_id_t    trace_id,
   input  trace_value_t trace_value,
   input  logic         entry_ready,
   output trace_entry_t entry,
   output logic         entry_valid
);

   timestamp_t   ts;
   drop_count_t  drop_cnt;
   trace_entry_t pend;
   logic         pend_valid;
   logic         sample;
   logic         slot_free;
   logic         have_drops;
   logic         to_pend;
   logic         drop_now;
   trace_entry_t ev;
   trace_entry_t ovf;

   assign sample     = trace_valid & ~stall;
   assign slot_free  = ~entry_valid | entry_ready;
   assign have_drops = (drop_cnt != '0);

   // pend only holds an event younger than every counted drop
   assign to_pend  = sample & slot_free & (pend_valid ? ~have_drops : have_drops);
   assign drop_now = sample & (~slot_free | (pend_valid & have_drops));

   assign ev  = '{is_overflow: 1'b0, timestamp: ts, id: trace_id, value: trace_value};
   assign ovf = '{is_overflow: 1'b1, timestamp: ts, id: '0,
                  value: trace_value_t'(drop_cnt)};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ts <= '0;
      end else begin
         ts <= ts + 1'b1; // free running
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         entry_valid <= 1'b0;
         pend_valid  <= 1'b0;
         drop_cnt    <= '0;
      end else begin
         if (slot_free) begin
            entry_valid <= pend_valid | have_drops | sample;
            pend_valid  <= to_pend;
         end
         if (slot_free & ~pend_valid & have_drops) begin
            drop_cnt <= '0; // overflow entry goes out now
         end else if (drop_now && drop_cnt != '1) begin
            drop_cnt <= drop_cnt + 1'b1; // saturates
         end
      end
   end

   always_ff @(posedge clk) begin
      if (slot_free) begin
         entry <= pend_valid ? pend : (have_drops ? ovf : ev);
      end
      if (to_pend) pend <= ev;
   end

endmodule

// File: source/stm_pkg.sv
`include "stm_defs.svh"

package stm_pkg;

   typedef logic [9:0]             node_id_t;
   typedef logic [`STM_FLIT_W-1:0] flit_data_t;
   typedef logic [`STM_TS_W-1:0]   timestamp_t;
   typedef logic [15:0]            trace_id_t;
   typedef logic [63:0]            trace_value_t;
   typedef logic [15:0]            drop_count_t;

   typedef struct packed {
      logic       valid;
      logic       last;
      flit_data_t data;
   } dii_flit_t;

   typedef struct packed {
      logic         is_overflow;
      timestamp_t   timestamp;
      trace_id_t    id;
      trace_value_t value; // drop count when is_overflow
   } trace_entry_t;

   typedef enum logic [1:0] {
      REG_RECV,
      REG_DECODE,
      REG_RESP
   } reg_state_e;

   typedef enum logic [1:0] {
      PKT_IDLE,
      PKT_HEADER,
      PKT_PAYLOAD
   } pkt_state_e;

endpackage

// File: source/stm_defs.svh
`ifndef STM_DEFS_SVH
`define STM_DEFS_SVH

`define STM_FLIT_W        16
`define STM_TS_W          32
`define STM_FIFO_DEPTH    8

`define STM_MOD_ID        16'h0004
`define STM_MOD_VERSION   16'h0000

`define STM_REG_ID        16'h0000
`define STM_REG_VERSION   16'h0001
`define STM_REG_CONTROL   16'h0200

`define STM_TYPE_REG_READ  16'h0001
`define STM_TYPE_REG_WRITE 16'h0002
`define STM_TYPE_RESP_OK   16'h0003
`define STM_TYPE_RESP_ERR  16'h0004
`define STM_TYPE_EVENT     16'h0010
`define STM_TYPE_OVERFLOW  16'h0011

`endif
